// ==== run_sim.sh ====
#!/bin/sh
# build the L2 testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module l2_subsystem_tb -o l2_sim \
	> build.log 2>&1 \
	&& ./obj_dir/l2_sim > sim.log 2>&1 \
	; cat build.log sim.log 2>/dev/null \
	; grep -qx "sim passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== sim.f ====
+incdir+include
verilog/lc3b_types.sv
verilog/l2_cache_lru.sv
verilog/l2_cache_datapath.sv
verilog/l2_cache_control.sv
verilog/l2_arbiter.sv
verilog/l2_subsystem.sv
tb/pmem_model.sv
tb/l2_subsystem_tb.sv

// ==== include/l2_tb_tasks.svh ====
`ifndef l2_tb_tasks_svh
`define l2_tb_tasks_svh

task automatic check_block(input string what, input lc3b_c_block exp, input lc3b_c_block got);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
	end
endtask

task automatic check_word(input string what, input lc3b_word exp, input lc3b_word got);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
	end
endtask

task automatic check_count(input string what, input int exp, input int got);
	checks++;
	if (got != exp)
	begin
		errors++;
		$display("ERR %0t: %s expected %0d got %0d", $time, what, exp, got);
	end
endtask

// reference starts as the physical memory image, kept in half blocks
task automatic load_reference();
	lc3b_l2_block blk;
	for (int b = 0; b < 2048; b++)
	begin
		blk = pmem.mem[b[10:0]];
		ref_mem[{b[10:0], 1'b0}] = blk[127:0];
		ref_mem[{b[10:0], 1'b1}] = blk[255:128];
	end
endtask

task automatic drive_port(input bit use_d, input bit rd, input bit wr,
	input lc3b_word addr, input lc3b_c_block wdata);
	if (use_d)
	begin
		d_read = rd;
		d_write = wr;
		d_address = addr;
		d_wdata = wdata;
	end
	else
	begin
		i_read = rd;
		i_write = wr;
		i_address = addr;
		i_wdata = wdata;
	end
endtask

// called 1 ns after a rising edge, returns 1 ns after the edge that ends resp
task automatic l1_request(input bit use_d, input bit wr, input lc3b_word addr,
	input lc3b_c_block wdata, output lc3b_c_block rdata);
	int waited;
	bit got;
	waited = 0;
	got = 1'b0;
	rdata = '0;
	drive_port(use_d, !wr, wr, addr, wdata);
	while (!got && waited < 200)
	begin
		@(negedge clk);
		if (use_d ? d_resp : i_resp)
		begin
			got = 1'b1;
			rdata = use_d ? d_rdata : i_rdata;
		end
		waited++;
	end
	@(posedge clk);
	#1;
	drive_port(use_d, 1'b0, 1'b0, addr, wdata);
	if (!got)
	begin
		errors++;
		$display("no response on the %s port for address %h", use_d ? "d" : "i", addr);
	end
endtask

task automatic read_check(input bit use_d, input lc3b_word addr);
	lc3b_c_block got;
	l1_request(use_d, 1'b0, addr, '0, got);
	check_block($sformatf("read %h", addr), ref_mem[addr[15:4]], got);
endtask

task automatic read_counted(input bit use_d, input lc3b_word addr, input int new_reads);
	int rd_before;
	rd_before = rd_beats;
	read_check(use_d, addr);
	check_count($sformatf("pmem reads for %h", addr), new_reads, rd_beats - rd_before);
endtask

task automatic write_ref(input bit use_d, input lc3b_word addr, input lc3b_c_block data);
	lc3b_c_block unused;
	l1_request(use_d, 1'b1, addr, data, unused);
	ref_mem[addr[15:4]] = data;
endtask

task automatic report_test(input string name, input int err_mark);
	if (errors == err_mark)
		$display("test %s: ok", name);
	else
		$display("test %s: %0d errors", name, errors - err_mark);
endtask

`endif

// ==== tb/l2_subsystem_tb.sv ====
`timescale 1ns/10ps

module l2_subsystem_tb;
	import lc3b_types::*;

	// every request bounded by a miss with writeback
	localparam int total_requests = 50;
	localparam int worst_miss_cycles = 40;
	localparam int watchdog_cycles = total_requests * worst_miss_cycles;

	logic clk = 1'b0;
	logic arst_n;
	logic i_read;
	logic i_write;
	lc3b_word i_address;
	lc3b_c_block i_wdata;
	logic i_resp;
	lc3b_c_block i_rdata;
	logic d_read;
	logic d_write;
	lc3b_word d_address;
	lc3b_c_block d_wdata;
	logic d_resp;
	lc3b_c_block d_rdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_l2_block pmem_wdata;
	logic pmem_resp;
	lc3b_l2_block pmem_rdata;

	int errors;
	int checks;
	int rd_beats;
	int wr_beats;
	int stray_resps = 0;
	lc3b_c_block ref_mem [4096];

	`include "l2_tb_tasks.svh"

	l2_subsystem UUT
	(
		.clk, .arst_n,
		.i_read, .i_write, .i_address, .i_wdata, .i_resp, .i_rdata,
		.d_read, .d_write, .d_address, .d_wdata, .d_resp, .d_rdata,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata, .pmem_resp, .pmem_rdata
	);

	pmem_model pmem
	(
		.clk, .arst_n,
		.read(pmem_read),
		.write(pmem_write),
		.address(pmem_address),
		.wdata(pmem_wdata),
		.resp(pmem_resp),
		.rdata(pmem_rdata)
	);

	always #2 clk = ~clk;

	// one beat per pmem_resp
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_beats <= 0;
			wr_beats <= 0;
		end
		else
		begin
			if (pmem_resp && pmem_read)
				rd_beats <= rd_beats + 1;
			if (pmem_resp && pmem_write)
				wr_beats <= wr_beats + 1;
		end
	end

	always @(negedge clk)
	begin
		if (arst_n && i_resp && !(i_read || i_write))
		begin
			stray_resps <= stray_resps + 1;
			$display("i_resp pulsed at %0t while the i port had no request", $time);
		end
		if (arst_n && d_resp && !(d_read || d_write))
		begin
			stray_resps <= stray_resps + 1;
			$display("d_resp pulsed at %0t while the d port had no request", $time);
		end
	end

	task automatic read_miss_test();
		read_counted(1'b1, 16'h1230, 1);
		check_word("fill address", 16'h1220, pmem.last_raddr);
	endtask

	task automatic read_hit_test();
		read_counted(1'b1, 16'h1220, 0);
	endtask

	task automatic write_evict_test();
		lc3b_c_block wdata;
		int rd_before;
		int wr_before;
		wdata = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
		rd_before = rd_beats;
		wr_before = wr_beats;
		write_ref(1'b1, 16'h1230, wdata);
		check_count("pmem reads on write hit", 0, rd_beats - rd_before);
		read_counted(1'b0, 16'h1230, 0);
		// set 1 fills ways 1 to 3 and then the tree picks way 0
		read_counted(1'b1, 16'h2120, 1);
		read_counted(1'b1, 16'h2220, 1);
		read_counted(1'b1, 16'h2320, 1);
		read_counted(1'b1, 16'h2420, 1);
		check_count("pmem writes", 1, wr_beats - wr_before);
		check_word("writeback address", 16'h1220, pmem.last_waddr);
		check_block("writeback low half", ref_mem[12'h122], pmem.last_wdata[127:0]);
		check_block("writeback high half", wdata, pmem.last_wdata[255:128]);
	endtask

	task automatic plru_test();
		int wr_before;
		wr_before = wr_beats;
		read_counted(1'b1, 16'h3140, 1);
		read_counted(1'b1, 16'h3240, 1);
		read_counted(1'b1, 16'h3340, 1);
		read_counted(1'b1, 16'h3440, 1);
		read_counted(1'b1, 16'h3140, 0);
		// A sends the top bit to ways 2/3 where D is newer than C
		read_counted(1'b1, 16'h3540, 1);
		read_counted(1'b1, 16'h3240, 0);
		read_counted(1'b1, 16'h3340, 1);
		read_counted(1'b1, 16'h3140, 0);
		check_count("pmem writes for clean victims", 0, wr_beats - wr_before);
	endtask

	task automatic dual_port_test();
		lc3b_c_block d_got;
		lc3b_c_block i_got;
		time d_done;
		time i_done;
		int rd_before;
		rd_before = rd_beats;
		fork
			begin
				l1_request(1'b1, 1'b0, 16'h4160, '0, d_got);
				d_done = $time;
			end
			begin
				l1_request(1'b0, 1'b0, 16'h4270, '0, i_got);
				i_done = $time;
			end
		join
		check_block("d port data", ref_mem[12'h416], d_got);
		check_block("i port data", ref_mem[12'h427], i_got);
		check_count("pmem reads", 2, rd_beats - rd_before);
		if (d_done >= i_done)
		begin
			errors++;
			$display("d port did not finish first (d at %0t, i at %0t)", d_done, i_done);
		end
	endtask

	task automatic random_test();
		int unsigned r;
		lc3b_word addr;
		lc3b_c_block data;
		for (int n = 0; n < 30; n++)
		begin
			r = $urandom();
			// eight tags over sets 4 to 7 to force dirty evictions
			addr = {5'b10100, r[2:0], 1'b1, r[4:3], r[5], r[9:6]};
			data = {$urandom(), $urandom(), $urandom(), $urandom()};
			if (r[11])
				write_ref(r[10], addr, data);
			else
				read_check(r[10], addr);
		end
	endtask

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		int err_mark;
		i_read = 1'b0;
		i_write = 1'b0;
		i_address = '0;
		i_wdata = '0;
		d_read = 1'b0;
		d_write = 1'b0;
		d_address = '0;
		d_wdata = '0;
		arst_n = 1'b0;
		errors = 0;
		checks = 0;
		void'($urandom(32'h9ea0088a));
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		load_reference();

		err_mark = errors;
		read_miss_test();
		report_test("read miss", err_mark);
		err_mark = errors;
		read_hit_test();
		report_test("read hit", err_mark);
		err_mark = errors;
		write_evict_test();
		report_test("write hit and writeback", err_mark);
		err_mark = errors;
		plru_test();
		report_test("pseudo-LRU victim", err_mark);
		err_mark = errors;
		dual_port_test();
		report_test("dual port arbitration", err_mark);
		err_mark = errors;
		random_test();
		report_test("random traffic", err_mark);

		$display("%0d checks, %0d errors, %0d stray responses", checks, errors, stray_resps);
		if (errors == 0 && stray_resps == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule : l2_subsystem_tb

// ==== tb/pmem_model.sv ====
`timescale 1ns/10ps

module pmem_model
(
	input clk,
	input arst_n,
	input read,
	input write,
	input lc3b_types::lc3b_word address,
	input lc3b_types::lc3b_l2_block wdata,
	output logic resp,
	output lc3b_types::lc3b_l2_block rdata
);
	import lc3b_types::*;

	localparam int resp_delay = 3;

	lc3b_l2_block mem [2048];
	int wait_cnt;

	// log of the last transfers
	lc3b_word last_raddr;
	lc3b_word last_waddr;
	lc3b_l2_block last_wdata;

	// every 16-bit word is a mix of its own byte address
	function automatic lc3b_l2_block fill_block(input int idx);
		lc3b_l2_block blk;
		lc3b_word a;
		blk = '0;
		for (int k = 0; k < 16; k++)
		begin
			a = {idx[10:0], k[3:0], 1'b0};
			blk[k*16 +: 16] = a * 16'h9e37 + 16'h5a3c;
		end
		return blk;
	endfunction

	initial
	begin
		for (int i = 0; i < 2048; i++)
			mem[i[10:0]] = fill_block(i);
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			resp <= 1'b0;
			rdata <= '0;
			wait_cnt <= 0;
		end
		else
		begin
			resp <= 1'b0;
			if ((read || write) && !resp)
			begin
				if (wait_cnt == resp_delay - 1)
				begin
					wait_cnt <= 0;
					resp <= 1'b1;
					if (write)
					begin
						mem[address[15:5]] <= wdata;
						last_waddr <= address;
						last_wdata <= wdata;
					end
					else
					begin
						rdata <= mem[address[15:5]];
						last_raddr <= address;
					end
				end
				else
					wait_cnt <= wait_cnt + 1;
			end
			else
				wait_cnt <= 0;
		end
	end

endmodule : pmem_model

// ==== verilog/l2_arbiter.sv ====
`timescale 1ns/10ps

module l2_arbiter
(
	input clk,
	input arst_n,
	input i_read,
	input i_write,
	input lc3b_types::lc3b_word i_address,
	input lc3b_types::lc3b_c_block i_wdata,
	output logic i_resp,
	output lc3b_types::lc3b_c_block i_rdata,
	input d_read,
	input d_write,
	input lc3b_types::lc3b_word d_address,
	input lc3b_types::lc3b_c_block d_wdata,
	output logic d_resp,
	output lc3b_types::lc3b_c_block d_rdata,
	output logic mem_read,
	output logic mem_write,
	output lc3b_types::lc3b_word mem_address,
	output lc3b_types::lc3b_c_block mem_wdata,
	input mem_resp,
	input lc3b_types::lc3b_c_block mem_rdata
);
	import lc3b_types::*;

	logic [1:0] owner;

	// data side wins a tie
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			owner <= own_none;
		else if (owner == own_none)
		begin
			if (d_read || d_write)
				owner <= own_dcache;
			else if (i_read || i_write)
				owner <= own_icache;
		end
		else if (mem_resp)
			owner <= own_none;
	end

	always_comb
	begin
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = d_address;
		mem_wdata = d_wdata;
		case (owner)
			own_dcache:
			begin
				mem_read = d_read;
				mem_write = d_write;
			end
			own_icache:
			begin
				mem_read = i_read;
				mem_write = i_write;
				mem_address = i_address;
				mem_wdata = i_wdata;
			end
			default: ;
		endcase
	end

	assign i_resp = mem_resp && (owner == own_icache);
	assign d_resp = mem_resp && (owner == own_dcache);
	assign i_rdata = mem_rdata;
	assign d_rdata = mem_rdata;

endmodule : l2_arbiter

// ==== verilog/l2_cache_control.sv ====
`timescale 1ns/10ps

module l2_cache_control
(
	input clk,
	input arst_n,
	input mem_read,
	input mem_write,
	input hit,
	input [3:0] way_hit,
	input [3:0] way_valid,
	input victim_dirty,
	input lc3b_types::lc3b_way_sel victim,
	input pmem_resp,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output logic [3:0] ld_way,
	output logic [3:0] ld_tag,
	output logic [3:0] ld_valid,
	output logic [3:0] ld_dirty,
	output logic dirty_in,
	output logic ld_hit,
	output logic ld_evict,
	output logic fill_sel,
	output lc3b_types::lc3b_way_sel evict_way,
	output logic addr_sel,
	output lc3b_types::lc3b_way_sel lru_way,
	output logic ld_lru
);
	import lc3b_types::*;

	logic [2:0] state;
	logic [2:0] next_state;
	lc3b_way_sel fill_way_q;
	lc3b_way_sel choice;
	logic [3:0] fill_onehot;

	// invalid ways go first
	always_comb
	begin
		if (!way_valid[0])
			choice = 2'd0;
		else if (!way_valid[1])
			choice = 2'd1;
		else if (!way_valid[2])
			choice = 2'd2;
		else if (!way_valid[3])
			choice = 2'd3;
		else
			choice = victim;
	end

	always_comb
	begin
		case (way_hit)
			4'b0010: lru_way = 2'd1;
			4'b0100: lru_way = 2'd2;
			4'b1000: lru_way = 2'd3;
			default: lru_way = 2'd0;
		endcase
	end

	assign fill_onehot = 4'b0001 << fill_way_q;
	assign evict_way = (state == s_compare) ? choice : fill_way_q;

	always_comb
	begin
		next_state = state;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		ld_way = '0;
		ld_tag = '0;
		ld_valid = '0;
		ld_dirty = '0;
		dirty_in = 1'b0;
		ld_hit = 1'b0;
		ld_evict = 1'b0;
		fill_sel = 1'b0;
		addr_sel = 1'b0;
		ld_lru = 1'b0;
		case (state)
			s_idle:
			begin
				ld_hit = 1'b1;
				if (mem_read || mem_write)
					next_state = s_compare;
			end
			s_compare:
			begin
				if (hit)
				begin
					mem_resp = 1'b1;
					ld_lru = 1'b1;
					if (mem_write)
					begin
						ld_way = way_hit;
						ld_dirty = way_hit;
						dirty_in = 1'b1;
					end
					next_state = s_idle;
				end
				else
				begin
					ld_evict = 1'b1;
					next_state = victim_dirty ? s_writeback : s_fill;
				end
			end
			s_writeback:
			begin
				pmem_write = 1'b1;
				addr_sel = 1'b1;
				if (pmem_resp)
					next_state = s_fill;
			end
			s_fill:
			begin
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					fill_sel = 1'b1;
					ld_way = fill_onehot;
					ld_tag = fill_onehot;
					ld_valid = fill_onehot;
					ld_dirty = fill_onehot;
					next_state = s_access;
				end
			end
			s_access:
			begin
				// relatch compare on the freshly filled block
				ld_hit = 1'b1;
				next_state = s_compare;
			end
			default: next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_idle;
			fill_way_q <= '0;
		end
		else
		begin
			state <= next_state;
			if (ld_evict)
				fill_way_q <= choice;
		end
	end

endmodule : l2_cache_control

// ==== verilog/l2_cache_datapath.sv ====
`timescale 1ns/10ps

module l2_cache_datapath
(
	input clk,
	input arst_n,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_c_block mem_wdata,
	input lc3b_types::lc3b_l2_block pmem_rdata,
	input [3:0] ld_way,
	input [3:0] ld_tag,
	input [3:0] ld_valid,
	input [3:0] ld_dirty,
	input dirty_in,
	input ld_hit,
	input ld_evict,
	input fill_sel,
	input lc3b_types::lc3b_way_sel evict_way,
	input addr_sel,
	input lc3b_types::lc3b_way_sel lru_way,
	input ld_lru,
	output logic hit,
	output logic [3:0] way_hit,
	output logic [3:0] way_valid,
	output logic victim_dirty,
	output lc3b_types::lc3b_way_sel victim,
	output lc3b_types::lc3b_c_block mem_rdata,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_l2_block pmem_wdata
);
	import lc3b_types::*;

	lc3b_l2_block way_mem [l2_ways][l2_sets];
	lc3b_l2_tag tag_mem [l2_ways][l2_sets];
	logic [l2_ways-1:0][l2_sets-1:0] valid_q;
	logic [l2_ways-1:0][l2_sets-1:0] dirty_q;

	lc3b_l2_addr req;
	lc3b_l2_addr fill_addr;
	lc3b_l2_addr evict_addr;
	lc3b_word evict_addr_q;
	lc3b_l2_block evict_data_q;

	lc3b_l2_block way_out [l2_ways];
	lc3b_l2_tag tag_out [l2_ways];
	logic [l2_ways-1:0] tag_match;
	lc3b_l2_block sel_block;
	lc3b_l2_block update_block;
	lc3b_l2_block way_in;

	assign req = mem_address;

	for (genvar w = 0; w < l2_ways; w++)
	begin : g_way
		always_ff @(posedge clk)
		begin
			if (ld_way[w])
				way_mem[w][req.f.line] <= way_in;
			if (ld_tag[w])
				tag_mem[w][req.f.line] <= req.f.tag;
		end

		assign way_out[w] = way_mem[w][req.f.line];
		assign tag_out[w] = tag_mem[w][req.f.line];
		assign way_valid[w] = valid_q[w][req.f.line];
		assign tag_match[w] = valid_q[w][req.f.line] && (tag_out[w] == req.f.tag);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else
		begin
			for (int w = 0; w < l2_ways; w++)
			begin
				if (ld_valid[w])
					valid_q[w][req.f.line] <= 1'b1;
				if (ld_dirty[w])
					dirty_q[w][req.f.line] <= dirty_in;
			end
		end
	end

	// compare result held for the access cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hit <= 1'b0;
			way_hit <= '0;
		end
		else if (ld_hit)
		begin
			hit <= |tag_match;
			way_hit <= tag_match;
		end
	end

	// way_hit is one-hot or zero
	always_comb
	begin
		sel_block = '0;
		for (int w = 0; w < l2_ways; w++)
			if (way_hit[w])
				sel_block = way_out[w];
	end

	assign update_block = req.f.offset ? {mem_wdata, sel_block[127:0]}
		: {sel_block[255:128], mem_wdata};
	assign way_in = fill_sel ? pmem_rdata : update_block;
	assign mem_rdata = req.f.offset ? sel_block[255:128] : sel_block[127:0];

	assign victim_dirty = dirty_q[evict_way][req.f.line];

	always_comb
	begin
		fill_addr = req;
		fill_addr.f.offset = 1'b0;
		fill_addr.f.byte_idx = 4'h0;
	end

	always_comb
	begin
		evict_addr.raw = '0;
		evict_addr.f.tag = tag_out[evict_way];
		evict_addr.f.line = req.f.line;
	end

	// evict buffer
	always_ff @(posedge clk)
	begin
		if (ld_evict)
		begin
			evict_addr_q <= evict_addr.raw;
			evict_data_q <= way_out[evict_way];
		end
	end

	assign pmem_address = addr_sel ? evict_addr_q : fill_addr.raw;
	assign pmem_wdata = evict_data_q;

	l2_cache_lru lru
	(
		.clk,
		.arst_n,
		.index(req.f.line),
		.ld_lru,
		.way(lru_way),
		.victim
	);

endmodule : l2_cache_datapath

// ==== verilog/l2_cache_lru.sv ====
`timescale 1ns/10ps

module l2_cache_lru
(
	input clk,
	input arst_n,
	input lc3b_types::lc3b_l2_line index,
	input ld_lru,
	input lc3b_types::lc3b_way_sel way,
	output lc3b_types::lc3b_way_sel victim
);
	import lc3b_types::*;

	lc3b_lru lru_q [l2_sets];
	lc3b_lru cur;
	lc3b_lru nxt;

	assign cur = lru_q[index];

	// top bit points at the half to evict next
	always_comb
	begin
		nxt = cur;
		case (way)
			2'd0: nxt = {2'b11, cur[0]};
			2'd1: nxt = {2'b10, cur[0]};
			2'd2: nxt = {1'b0, cur[1], 1'b1};
			default: nxt = {1'b0, cur[1], 1'b0};
		endcase
	end

	assign victim = cur[2] ? {1'b1, cur[0]} : {1'b0, cur[1]};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int s = 0; s < l2_sets; s++)
				lru_q[s] <= '0;
		end
		else if (ld_lru)
			lru_q[index] <= nxt;
	end

endmodule : l2_cache_lru

// ==== verilog/l2_subsystem.sv ====
`timescale 1ns/10ps

module l2_subsystem
(
	input clk,
	input arst_n,
	input i_read,
	input i_write,
	input lc3b_types::lc3b_word i_address,
	input lc3b_types::lc3b_c_block i_wdata,
	output logic i_resp,
	output lc3b_types::lc3b_c_block i_rdata,
	input d_read,
	input d_write,
	input lc3b_types::lc3b_word d_address,
	input lc3b_types::lc3b_c_block d_wdata,
	output logic d_resp,
	output lc3b_types::lc3b_c_block d_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_l2_block pmem_wdata,
	input pmem_resp,
	input lc3b_types::lc3b_l2_block pmem_rdata
);
	import lc3b_types::*;

	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	lc3b_c_block mem_wdata;
	logic mem_resp;
	lc3b_c_block mem_rdata;

	logic hit;
	logic [3:0] way_hit;
	logic [3:0] way_valid;
	logic victim_dirty;
	lc3b_way_sel victim;
	logic [3:0] ld_way;
	logic [3:0] ld_tag;
	logic [3:0] ld_valid;
	logic [3:0] ld_dirty;
	logic dirty_in;
	logic ld_hit;
	logic ld_evict;
	logic fill_sel;
	lc3b_way_sel evict_way;
	logic addr_sel;
	lc3b_way_sel lru_way;
	logic ld_lru;

	l2_arbiter arbiter
	(
		.clk, .arst_n,
		.i_read, .i_write, .i_address, .i_wdata, .i_resp, .i_rdata,
		.d_read, .d_write, .d_address, .d_wdata, .d_resp, .d_rdata,
		.mem_read, .mem_write, .mem_address, .mem_wdata, .mem_resp, .mem_rdata
	);

	l2_cache_control control
	(
		.clk, .arst_n,
		.mem_read, .mem_write, .hit, .way_hit, .way_valid, .victim_dirty, .victim,
		.pmem_resp, .mem_resp, .pmem_read, .pmem_write,
		.ld_way, .ld_tag, .ld_valid, .ld_dirty, .dirty_in, .ld_hit, .ld_evict,
		.fill_sel, .evict_way, .addr_sel, .lru_way, .ld_lru
	);

	l2_cache_datapath datapath
	(
		.clk, .arst_n,
		.mem_address, .mem_wdata, .pmem_rdata,
		.ld_way, .ld_tag, .ld_valid, .ld_dirty, .dirty_in, .ld_hit, .ld_evict,
		.fill_sel, .evict_way, .addr_sel, .lru_way, .ld_lru,
		.hit, .way_hit, .way_valid, .victim_dirty, .victim,
		.mem_rdata, .pmem_address, .pmem_wdata
	);

endmodule : l2_subsystem

// ==== verilog/lc3b_types.sv ====
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [127:0] lc3b_c_block;
	typedef logic [255:0] lc3b_l2_block;

	typedef logic [7:0] lc3b_l2_tag;
	typedef logic [2:0] lc3b_l2_line;
	typedef logic lc3b_l2_offset;

	// tree bits: top, low half (ways 0/1), high half (ways 2/3)
	typedef logic [2:0] lc3b_lru;
	typedef logic [1:0] lc3b_way_sel;

	typedef union packed
	{
		lc3b_word raw;
		struct packed
		{
			lc3b_l2_tag tag;
			lc3b_l2_line line;
			lc3b_l2_offset offset;
			logic [3:0] byte_idx;
		} f;
	} lc3b_l2_addr;

	localparam int l2_ways = 4;
	localparam int l2_sets = 8;

	// cache controller states
	localparam logic [2:0] s_idle = 3'd0;
	localparam logic [2:0] s_compare = 3'd1;
	localparam logic [2:0] s_access = 3'd2;
	localparam logic [2:0] s_writeback = 3'd3;
	localparam logic [2:0] s_fill = 3'd4;

	// arbiter owner codes
	localparam logic [1:0] own_none = 2'd0;
	localparam logic [1:0] own_icache = 2'd1;
	localparam logic [1:0] own_dcache = 2'd2;

endpackage : lc3b_types
